// ==== compile.f ====
+incdir+rtl
rtl/rx_word_pkg.sv
rtl/rx_link_pkg.sv
rtl/rx_lock_wait.sv
rtl/rx_deserializer.sv
rtl/rx_word_queue.sv
rtl/rx_top.sv
tests/rx_top_chk.sv
tests/rx_top_tb.sv

// ==== tests/rx_top_tb.sv ====
// Testbench for the serial receive front end
// Random serial bits and credit returns, checked every cycle against
// a model of the lock wait, deserializer and credit queue

`timescale 1ns/100ps

`include "rx_macros.svh"

module rx_top_tb
    import rx_word_pkg::*;
    import rx_link_pkg::*;
();

    localparam int WORD_W = `RX_WORD_WIDTH;

    // ******************************
    // DUT signals
    // ******************************
    logic     fabric_clk_div;
    logic     reset_buf_n;
    logic     serial_in;
    logic     enable_n;
    logic     credit_return;
    rx_link_t link_out;
    logic     ready;
    logic     overflow;

    logic [31:0] lcg_state;
    logic        force_disable;  // Hold enable_n high
    logic        hold_credits;   // Consumer keeps its credits
    int          outstanding;    // Received words not yet credited back
    int          delivered;
    int          held_start;
    int          mismatch_cnt;
    int          other_cnt;
    int          assert_cnt;

    // ******************************
    // Model state
    // ******************************
    int                m_edge;       // Rising edges since reset release
    logic [WORD_W-1:0] m_shift;
    rx_word_t          m_word;       // Completed word, valid one cycle
    logic              m_ready;
    logic [WORD_W-1:0] m_fifo [$];
    credit_cnt_t       m_credits;
    logic              m_overflow;
    rx_link_t          m_link;

    always #2 fabric_clk_div = ~fabric_clk_div;  // 4 ns period

    rx_top u_rx_top (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .serial_in      (serial_in),
        .enable_n       (enable_n),
        .credit_return  (credit_return),
        .link_out       (link_out),
        .ready          (ready),
        .overflow       (overflow)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic model_reset();
        m_edge     = 0;
        m_shift    = '0;
        m_word     = '0;
        m_ready    = 1'b0;
        m_fifo.delete();
        m_credits  = credit_cnt_t'(`RX_LINK_CREDITS);
        m_overflow = 1'b0;
        m_link     = '0;
    endtask

    task automatic model_step();
        logic gated;
        logic word_in;
        logic pop;
        logic push;
        gated   = serial_in & ~enable_n;                // Enable is active low
        word_in = m_word.valid && m_ready;              // Dropped before lock
        pop     = (m_fifo.size() != 0) && (m_credits != 0);
        push    = word_in && (m_fifo.size() < `RX_QUEUE_DEPTH || pop);
        if (word_in && !push) begin
            m_overflow = 1'b1;                          // Full, nothing leaving
        end
        m_link.valid = pop;
        if (pop) begin
            m_link.data = m_fifo.pop_front();
        end
        if (push) begin
            m_fifo.push_back(m_word.data);
        end
        m_credits = m_credits - credit_cnt_t'(pop) + credit_cnt_t'(credit_return);
        m_edge++;
        m_shift      = {m_shift[WORD_W-2:0], gated};    // First bit ends up MSB
        m_word.valid = (m_edge % WORD_W == 0);
        if (m_word.valid) begin
            m_word.data = m_shift;
        end
        m_ready = m_ready || (m_edge >= `RX_LOCK_CYCLES);
    endtask

    always @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            model_reset();
        end else begin
            model_step();
        end
    end

    // ******************************
    // Compare tasks
    // ******************************
    task automatic check_link(input rx_link_t got, input rx_link_t exp);
        if (got.valid !== exp.valid) begin
            mismatch_cnt++;
            $display("mismatch link_out.valid: got 0x%h expected 0x%h", got.valid, exp.valid);
        end else if (exp.valid && got.data !== exp.data) begin
            mismatch_cnt++;
            $display("mismatch link_out.data: got 0x%h expected 0x%h", got.data, exp.data);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic compare_outputs();
        check_flag("ready", ready, m_ready);
        check_flag("overflow", overflow, m_overflow);
        check_link(link_out, m_link);
        if (link_out.valid === 1'b1) begin
            delivered++;
            outstanding++;                              // Consumer owes a credit
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        r         = lcg_next();
        serial_in = r[16];
        enable_n  = force_disable || (r[22:20] == 3'd0); // Short random gaps
        if (!hold_credits && outstanding > 0 && r[27:26] != 2'd0) begin
            credit_return = 1'b1;
            outstanding--;
        end else begin
            credit_return = 1'b0;
        end
    endtask

    // ******************************
    // Cycle and wait helpers
    // ******************************
    task automatic step_cycle();
        @(negedge fabric_clk_div);
        if (reset_buf_n) begin
            compare_outputs();
        end
        drive_inputs();
    endtask

    task automatic run_cycles(input int count);
        for (int i = 0; i < count; i++) begin
            step_cycle();
        end
    endtask

    task automatic apply_reset();
        @(negedge fabric_clk_div);
        reset_buf_n   = 1'b0;
        credit_return = 1'b0;
        outstanding   = 0;
        @(negedge fabric_clk_div);
        check_flag("ready", ready, 1'b0);               // Async clear
        check_flag("overflow", overflow, 1'b0);
        check_flag("link_out.valid", link_out.valid, 1'b0);
        repeat (3) @(negedge fabric_clk_div);
        reset_buf_n = 1'b1;
        drive_inputs();                                 // Bit for edge 1
    endtask

    task automatic wait_ready(input int limit);
        int n;
        n = 0;
        while (ready !== 1'b1 && n < limit) begin
            step_cycle();
            n++;
        end
        if (ready !== 1'b1) begin
            other_cnt++;
            $display("timeout: ready did not rise within %0d cycles", limit);
        end else if (m_edge != `RX_LOCK_CYCLES) begin
            other_cnt++;
            $display("ready rose after edge %0d, not edge %0d", m_edge, `RX_LOCK_CYCLES);
        end
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while ((m_credits != credit_cnt_t'(`RX_LINK_CREDITS) || m_fifo.size() != 0)
               && n < limit) begin
            step_cycle();
            n++;
        end
        if (m_credits != credit_cnt_t'(`RX_LINK_CREDITS) || m_fifo.size() != 0) begin
            other_cnt++;
            $display("timeout: queue and credits did not settle within %0d cycles", limit);
        end
    endtask

    // ******************************
    // Test sequence
    // ******************************
    initial begin
        fabric_clk_div = 1'b0;
        reset_buf_n    = 1'b0;
        serial_in      = 1'b0;
        enable_n       = 1'b1;
        credit_return  = 1'b0;
        lcg_state      = 32'h2c366f08;
        force_disable  = 1'b0;
        hold_credits   = 1'b0;
        outstanding    = 0;
        delivered      = 0;
        held_start     = 0;
        mismatch_cnt   = 0;
        other_cnt      = 0;
        assert_cnt     = 0;

        apply_reset();
        wait_ready(`RX_LOCK_CYCLES + 40);               // Early words must not appear
        run_cycles(400);                                // Random bits and credits

        force_disable = 1'b1;                           // Whole words of zeros
        run_cycles(WORD_W * 8);
        force_disable = 1'b0;

        wait_drain(200);
        hold_credits = 1'b1;                            // Starve the link
        held_start   = delivered;
        run_cycles(WORD_W * 12);
        if (delivered - held_start > `RX_LINK_CREDITS) begin
            other_cnt++;
            $display("%0d words sent with credits withheld", delivered - held_start);
        end
        check_flag("overflow", overflow, 1'b1);
        hold_credits = 1'b0;
        wait_drain(200);                                // Queued words drain

        apply_reset();                                  // Overflow is set here
        run_cycles(40);

        assert_cnt = u_rx_top.u_rx_word_queue.u_rx_top_chk.fail_cnt;
        $display("Done: %0d words, %0d mismatches, %0d other errors, %0d assertion errors",
                 delivered, mismatch_cnt, other_cnt, assert_cnt);
        if (mismatch_cnt + other_cnt + assert_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule : rx_top_tb

// ==== tests/rx_top_chk.sv ====
// Link checker bound to the word queue
// Credit limits, reset values and sticky overflow

`timescale 1ns/100ps

`include "rx_macros.svh"

module rx_top_chk
    import rx_link_pkg::*;
(
    input logic        fabric_clk_div,
    input logic        reset_buf_n,
    input credit_cnt_t credit_cnt,
    input rx_link_t    link_out,
    input logic        overflow
);

    int fail_cnt = 0;  // Failed assertion count

    // ******************************
    // Credit rules
    // ******************************
    credit_gate_a: assert property (@(posedge fabric_clk_div) disable iff (!reset_buf_n)
        (credit_cnt == '0) |=> !link_out.valid)
    else begin
        fail_cnt++;
        $error("link_out.valid high after a cycle with no credit");
    end

    credit_max_a: assert property (@(posedge fabric_clk_div) disable iff (!reset_buf_n)
        credit_cnt <= credit_cnt_t'(`RX_LINK_CREDITS))
    else begin
        fail_cnt++;
        $error("credit count above the link credit limit");
    end

    // ******************************
    // Reset and overflow
    // ******************************
    reset_idle_a: assert property (@(posedge fabric_clk_div)
        !reset_buf_n |-> !link_out.valid)
    else begin
        fail_cnt++;
        $error("link_out.valid high during reset");
    end

    overflow_sticky_a: assert property (@(posedge fabric_clk_div) disable iff (!reset_buf_n)
        overflow |=> overflow)  // Only reset clears it
    else begin
        fail_cnt++;
        $error("overflow cleared without a reset");
    end

endmodule : rx_top_chk

bind rx_word_queue rx_top_chk u_rx_top_chk (
    .fabric_clk_div (fabric_clk_div),
    .reset_buf_n    (reset_buf_n),
    .credit_cnt     (credit_cnt),
    .link_out       (link_out),
    .overflow       (overflow)
);

// ==== rtl/rx_top.sv ====
// Serial receive front end
// Lock wait, deserializer and credit-based word queue

`timescale 1ns/100ps

module rx_top
    import rx_word_pkg::*;
    import rx_link_pkg::*;
(
    input  logic     fabric_clk_div,
    input  logic     reset_buf_n,
    input  logic     serial_in,
    input  logic     enable_n,
    input  logic     credit_return,
    output rx_link_t link_out,
    output logic     ready,
    output logic     overflow
);

    // ******************************
    // Internal wires
    // ******************************
    lock_state_e lock_state;   // From lock wait
    rx_word_t    word;         // Deserializer to queue

    assign ready = (lock_state == LOCK_READY);

    // ******************************
    // Lock wait
    // ******************************
    rx_lock_wait u_rx_lock_wait (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .lock_state     (lock_state)
    );

    // ******************************
    // Deserializer
    // ******************************
    rx_deserializer u_rx_deserializer (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .serial_in      (serial_in),
        .enable_n       (enable_n),
        .word           (word)
    );

    // ******************************
    // Queue and link sender
    // ******************************
    rx_word_queue u_rx_word_queue (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .word           (word),
        .lock_state     (lock_state),
        .credit_return  (credit_return),
        .link_out       (link_out),
        .overflow       (overflow)
    );

endmodule : rx_top

// ==== rtl/rx_word_queue.sv ====
// Word queue and credit link sender
// Accepts words only once locked, buffers them in a small FIFO and
// sends one per cycle while credits remain, with sticky overflow

`timescale 1ns/100ps

`include "rx_macros.svh"

module rx_word_queue
    import rx_word_pkg::*;
    import rx_link_pkg::*;
(
    input  logic        fabric_clk_div,
    input  logic        reset_buf_n,
    input  rx_word_t    word,
    input  lock_state_e lock_state,
    input  logic        credit_return,
    output rx_link_t    link_out,
    output logic        overflow
);

    localparam int DEPTH  = `RX_QUEUE_DEPTH;
    localparam int PTR_W  = $clog2(DEPTH);
    localparam int WORD_W = `RX_WORD_WIDTH;

    // ******************************
    // Storage and control
    // ******************************
    logic [WORD_W-1:0] fifo_mem [DEPTH];  // Payload only
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W:0]    fifo_cnt;          // 0 up to DEPTH
    logic              fifo_full;
    logic              fifo_empty;
    logic              word_in;           // Valid word while locked
    logic              push;
    logic              pop;
    logic              drop;              // Full with no room this cycle
    credit_cnt_t       credit_cnt;
    logic              link_valid_q;
    logic [WORD_W-1:0] link_data_q;

    assign fifo_full  = (fifo_cnt == (PTR_W + 1)'(DEPTH));
    assign fifo_empty = (fifo_cnt == '0);
    assign word_in    = word.valid && (lock_state == LOCK_READY); // Drop before lock
    assign pop        = !fifo_empty && (credit_cnt != '0);        // Needs a credit
    assign push       = word_in && (!fifo_full || pop);           // Pop frees a slot
    assign drop       = word_in && fifo_full && !pop;

    // ******************************
    // FIFO pointers and fill level
    // ******************************
    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
                2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
                default: fifo_cnt <= fifo_cnt;  // Both or neither
            endcase
        end
    end

    always_ff @(posedge fabric_clk_div) begin
        if (push) begin
            fifo_mem[wr_ptr] <= word.data;
        end
    end

    // ******************************
    // Credit counter
    // ******************************
    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            credit_cnt <= credit_cnt_t'(`RX_LINK_CREDITS); // Full credit at start
        end else begin
            case ({pop, credit_return})
                2'b10:   credit_cnt <= credit_cnt - 1'b1; // Spent on a send
                2'b01:   credit_cnt <= credit_cnt + 1'b1; // Returned by consumer
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // ******************************
    // Registered link output
    // ******************************
    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            link_valid_q <= 1'b0;
        end else begin
            link_valid_q <= pop;          // At most one word per cycle
        end
    end

    always_ff @(posedge fabric_clk_div) begin
        if (pop) begin
            link_data_q <= fifo_mem[rd_ptr];
        end
    end

    assign link_out = '{valid: link_valid_q, data: link_data_q};

    // Sticky until reset
    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            overflow <= 1'b0;
        end else if (drop) begin
            overflow <= 1'b1;
        end
    end

endmodule : rx_word_queue

// ==== rtl/rx_deserializer.sv ====
// Serial to word deserializer
// Samples one gated bit per edge, shifts it in MSB first and
// registers each completed word with a one-cycle valid

`timescale 1ns/100ps

`include "rx_macros.svh"

module rx_deserializer
    import rx_word_pkg::*;
(
    input  logic     fabric_clk_div,
    input  logic     reset_buf_n,
    input  logic     serial_in,
    input  logic     enable_n,
    output rx_word_t word
);

    localparam int WORD_W = `RX_WORD_WIDTH;
    localparam int CNT_W  = $clog2(WORD_W);

    // ******************************
    // Input gating
    // ******************************
    logic              bit_gated;    // Zero while disabled
    logic [CNT_W-1:0]  bit_cnt;      // Position inside current word
    logic              word_last;    // Last bit of a word this edge
    logic [WORD_W-1:0] shift_q;      // Partial word
    logic [WORD_W-1:0] shift_next;   // Shift register with this bit
    logic              word_valid_q;
    logic [WORD_W-1:0] word_data_q;

    assign bit_gated  = serial_in & ~enable_n;          // Active low enable
    assign shift_next = {shift_q[WORD_W-2:0], bit_gated}; // MSB first
    assign word_last  = (bit_cnt == CNT_W'(WORD_W - 1));

    // ******************************
    // Free-running bit counter
    // ******************************
    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            bit_cnt <= '0;                 // Edge 1 is bit 0 of word 0
        end else if (word_last) begin
            bit_cnt <= '0;                 // Wrap at word boundary
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // Shift register, fully refilled every word
    always_ff @(posedge fabric_clk_div) begin
        shift_q <= shift_next;
    end

    // ******************************
    // Word output register
    // ******************************
    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            word_valid_q <= 1'b0;
        end else begin
            word_valid_q <= word_last;     // High for one cycle
        end
    end

    always_ff @(posedge fabric_clk_div) begin
        if (word_last) begin
            word_data_q <= shift_next;     // Includes the bit sampled now
        end
    end

    assign word = '{valid: word_valid_q, data: word_data_q};

endmodule : rx_deserializer

// ==== rtl/rx_lock_wait.sv ====
// Lock-wait counter
// Holds the receiver in LOCK_WAIT for a fixed number of edges after
// reset, standing in for the clock source settling time

`timescale 1ns/100ps

`include "rx_macros.svh"

module rx_lock_wait
    import rx_word_pkg::*;
(
    input  logic        fabric_clk_div,
    input  logic        reset_buf_n,
    output lock_state_e lock_state
);

    // ******************************
    // Settling counter
    // ******************************
    logic [7:0]  wait_cnt;      // Saturates at lock count
    logic        wait_done;     // Counter reached its end
    logic        wait_last;     // Edge that completes the wait
    lock_state_e state_q;

    assign wait_done = (wait_cnt == 8'(`RX_LOCK_CYCLES));
    assign wait_last = (wait_cnt == 8'(`RX_LOCK_CYCLES - 1));

    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            wait_cnt <= '0;
        end else if (!wait_done) begin
            wait_cnt <= wait_cnt + 8'd1;  // Stop once settled
        end
    end

    // ******************************
    // Lock state
    // ******************************
    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            state_q <= LOCK_WAIT;
        end else if (state_q == LOCK_WAIT && wait_last) begin
            state_q <= LOCK_READY;        // Ready from the last wait edge on
        end
    end

    assign lock_state = state_q;

endmodule : rx_lock_wait

// ==== rtl/rx_link_pkg.sv ====
// Output link types
// Credit-based link word and the sender credit count

`include "rx_macros.svh"

package rx_link_pkg;

    // ******************************
    // Link word to the consumer
    // ******************************
    typedef struct packed {
        logic                      valid;  // One word per high cycle
        logic [`RX_WORD_WIDTH-1:0] data;   // Payload, same order as received
    } rx_link_t;

    // Credits held by the sender, 0 up to 4
    typedef logic [2:0] credit_cnt_t;

endpackage : rx_link_pkg

// ==== rtl/rx_word_pkg.sv ====
// Receive side types
// Deserializer word format and lock-wait state encoding

`include "rx_macros.svh"

package rx_word_pkg;

    // ******************************
    // Deserializer output word
    // ******************************
    typedef struct packed {
        logic                      valid;  // One cycle per completed word
        logic [`RX_WORD_WIDTH-1:0] data;   // First bit received is MSB
    } rx_word_t;

    // ******************************
    // Lock-wait state
    // ******************************
    typedef enum logic {
        LOCK_WAIT  = 1'b0,  // Settling after reset
        LOCK_READY = 1'b1   // Words may enter the queue
    } lock_state_e;

endpackage : rx_word_pkg

// ==== rtl/rx_macros.svh ====
// Receiver front end build constants
// Word size, lock settling time, queue depth and link credits

`ifndef RX_MACROS_SVH
`define RX_MACROS_SVH

// ******************************
// Word format
// ******************************
`define RX_WORD_WIDTH   4    // Bits per assembled word

// ******************************
// Lock and link
// ******************************
`define RX_LOCK_CYCLES  255  // Edges from reset release to ready
`define RX_QUEUE_DEPTH  4    // FIFO entries
`define RX_LINK_CREDITS 4    // Credits held by sender after reset

`endif
